// File: run_sim.sh
#!/usr/bin/env bash
# build and run the smac testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f smac.f --top-module smac_tb -o smac_sim

./obj_dir/smac_sim | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "run_sim: testbench reported failure, see $LOG"
  exit 1
fi

echo "run_sim: no failure found in $LOG"

// File: sim/smac_chk.sv
`timescale 1ns/1ps

module smac_chk (
  input logic clk,
  input logic reset_i,
  input logic ce_i,                                   // strobe at the top level
  input logic valid_i                                 // valid_o of the top level
);

  int fail_count = 0;                                 // assertion failures so far

  // a strobe sampled at edge k shows valid after edge k+2, seen at edge k+3
  assert property (@(posedge clk) disable iff (reset_i) ce_i |-> ##3 valid_i)
    else begin
      $error("valid_o missing three cycles after a strobe");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset_i) !ce_i |-> ##3 !valid_i)
    else begin
      $error("valid_o high three cycles after an idle cycle");
      fail_count++;
    end

  // synchronous reset clears the output pulse on the next edge
  assert property (@(posedge clk) reset_i |=> !valid_i)
    else begin
      $error("valid_o high while reset is applied");
      fail_count++;
    end

endmodule

bind smac_top smac_chk u_smac_chk (
  .clk     (clk),
  .reset_i (reset_i),
  .ce_i    (ce_i),
  .valid_i (valid_o)
);

// File: sim/smac_monitor.sv
`timescale 1ns/1ps

module smac_monitor (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        valid_i,        // valid_o of the DUT
  input  logic [smac_pkg::WORD_W-1:0] result_i,       // result_o of the DUT
  output int                          error_count_o,
  output int                          check_count_o
);
  import smac_pkg::*;

  logic [WORD_W-1:0] expected_q[$];                   // oldest result first
  int                errors = 0;
  int                checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  //////////////////////////////////////////////////////////////////////
  // queue access from the testbench
  //////////////////////////////////////////////////////////////////////

  task automatic push_expected(input logic [WORD_W-1:0] value);
    expected_q.push_back(value);
  endtask

  // items in flight are dropped by a reset
  task automatic flush_expected();
    expected_q.delete();
  endtask

  function automatic int pending_count();
    return expected_q.size();
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare
  //////////////////////////////////////////////////////////////////////

  // outputs change on the rising edge, so look on the falling one
  always @(negedge clk) begin
    logic [WORD_W-1:0] expected;
    if (!reset_i && valid_i) begin
      if (expected_q.size() == 0) begin
        $display("%0t ns: valid_o came out with no result expected", $time);
        errors++;
      end else begin
        expected = expected_q.pop_front();
        checks++;
        if (result_i !== expected) begin
          $display("[FAIL] %0t ns: result_o %h, expected %h", $time, result_i, expected);
          errors++;
        end
      end
    end
  end

endmodule

// File: sim/smac_tb.sv
`timescale 1ns/1ps

module smac_tb;
  import smac_pkg::*;

  localparam int ACC_W       = 64;                    // passed down to the DUT
  localparam int DRAIN_LIMIT = 50;                    // cycles to wait for results

  logic               clk;
  logic               reset_i;
  logic               ce_i;
  prec_e              prec_i;
  logic               accumulate_i;
  logic [WORD_W-1:0]  data_i;
  logic [WORD_W-1:0]  weight_i;
  logic [WORD_W-1:0]  result_o;
  logic               valid_o;
  int                 error_count;
  int                 check_count;
  integer             seed;
  logic signed [63:0] shadow_acc;                     // model of the DUT sum
  int                 tests_run;
  int                 checks_before;
  int                 errors_before;

  always #10 clk = ~clk;                              // 20 ns period

  smac_top #(
    .ACC_W (ACC_W)
  ) u_smac_top (
    .clk          (clk),
    .reset_i      (reset_i),
    .ce_i         (ce_i),
    .prec_i       (prec_i),
    .accumulate_i (accumulate_i),
    .data_i       (data_i),
    .weight_i     (weight_i),
    .result_o     (result_o),
    .valid_o      (valid_o)
  );

  smac_monitor u_smac_monitor (
    .clk           (clk),
    .reset_i       (reset_i),
    .valid_i       (valid_o),
    .result_i      (result_o),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // truncating bf16 multiply, zero on underflow, inf on overflow
  function automatic logic [15:0] bf16_mul_ref(input logic [15:0] x, input logic [15:0] y);
    int          ex;
    int          ey;
    int          e;
    int unsigned p;
    logic        s;
    logic [6:0]  m;
    s  = x[15] ^ y[15];
    ex = int'(x[14:7]);
    ey = int'(y[14:7]);
    p  = (128 + int'(x[6:0])) * (128 + int'(y[6:0]));  // significands with hidden one
    e  = ex + ey - BF16_BIAS;
    if (p >= 32768) begin                             // product of at least 2.0
      e = e + 1;
      m = 7'((p >> 8) & 127);
    end else begin
      m = 7'((p >> 7) & 127);
    end
    if (ex == 0 || ey == 0 || e <= 0) return {s, 15'd0};
    if (e >= 255) return {s, 8'hff, 7'd0};
    return {s, e[7:0], m};
  endfunction

  function automatic logic [63:0] smac_ref(input prec_e prec, input logic acc,
                                           input logic [63:0] d, input logic [63:0] w);
    longint a;
    longint b;
    longint sum;
    case (prec)
      PREC_INT8: begin
        a = {{56{d[7]}}, d[7:0]};
        b = {{56{w[7]}}, w[7:0]};
      end
      PREC_INT16: begin
        a = {{48{d[15]}}, d[15:0]};
        b = {{48{w[15]}}, w[15:0]};
      end
      PREC_INT32: begin
        a = {{32{d[31]}}, d[31:0]};
        b = {{32{w[31]}}, w[31:0]};
      end
      default: return {48'd0, bf16_mul_ref(d[15:0], w[15:0])};  // sum untouched
    endcase
    sum = (acc ? shadow_acc : 64'sd0) + a * b;
    sum = (sum <<< (64 - ACC_W)) >>> (64 - ACC_W);    // wrap to ACC_W, sign extend
    shadow_acc = sum;
    return sum;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // exponent drawn from exp_lo .. exp_lo+span-1
  function automatic logic [15:0] random_bf16(input int exp_lo, input int span);
    logic [31:0] r;
    int          e;
    r = $random(seed);
    e = exp_lo + int'(r[15:8]) % span;
    return {r[0], e[7:0], r[7:1]};
  endfunction

  task automatic send_item(input prec_e prec, input logic acc,
                           input logic [63:0] d, input logic [63:0] w);
    ce_i         = 1'b1;
    prec_i       = prec;
    accumulate_i = acc;
    data_i       = d;
    weight_i     = w;
    u_smac_monitor.push_expected(smac_ref(prec, acc, d, w));
    @(posedge clk);
    #1;
    ce_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // wait until every queued result has been compared
  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (u_smac_monitor.pending_count() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (u_smac_monitor.pending_count() != 0) begin
      $display("timeout: %0d results of test %s never came out",
               u_smac_monitor.pending_count(), name);
      $display("Simulation failed");
      $finish;
    end else begin
      tests_run++;
      $display("test %0d %s: %0d checks, %0d errors", tests_run, name,
               check_count - checks_before, error_count - errors_before);
      checks_before = check_count;
      errors_before = error_count;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    prec_e       p;
    int          total_errors;
    clk           = 1'b0;
    reset_i       = 1'b1;
    ce_i          = 1'b0;
    prec_i        = PREC_INT8;
    accumulate_i  = 1'b0;
    data_i        = '0;
    weight_i      = '0;
    seed          = 30814;
    shadow_acc    = '0;
    tests_run     = 0;
    checks_before = 0;
    errors_before = 0;
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // isolated signed products, upper junk must be ignored
    for (int i = 0; i < 4; i++) begin
      send_item(PREC_INT8, 1'b0, random_word(), random_word());
      idle_cycles(3);
      send_item(PREC_INT16, 1'b0, random_word(), random_word());
      idle_cycles(3);
      send_item(PREC_INT32, 1'b0, random_word(), random_word());
      idle_cycles(3);
    end
    send_item(PREC_INT8, 1'b0, 64'h80, 64'h80);        // most negative squared
    idle_cycles(3);
    send_item(PREC_INT8, 1'b0, 64'h80, 64'h7f);
    idle_cycles(3);
    send_item(PREC_INT16, 1'b0, 64'h8000, 64'h8000);
    idle_cycles(3);
    send_item(PREC_INT32, 1'b0, 64'h8000_0000, 64'h8000_0000);
    idle_cycles(3);
    send_item(PREC_INT32, 1'b0, 64'h8000_0000, 64'h7fff_ffff);
    idle_cycles(3);
    send_item(PREC_INT8, 1'b0, '1, '1);                // -1 * -1 in every width
    idle_cycles(3);
    send_item(PREC_INT16, 1'b0, '1, '1);
    idle_cycles(3);
    send_item(PREC_INT32, 1'b0, '1, '1);
    finish_test("integer products");

    // running sum, then a restart
    send_item(PREC_INT16, 1'b0, random_word(), random_word());
    for (int i = 0; i < 8; i++) send_item(PREC_INT16, 1'b1, random_word(), random_word());
    send_item(PREC_INT16, 1'b0, random_word(), random_word());
    for (int i = 0; i < 3; i++) send_item(PREC_INT16, 1'b1, random_word(), random_word());
    finish_test("accumulation");

    for (int i = 0; i < 6; i++) begin
      send_item(PREC_BF16, i[0], {random_word()} & ~64'hffff | 64'(random_bf16(100, 55)),
                {random_word()} & ~64'hffff | 64'(random_bf16(100, 55)));
    end
    send_item(PREC_BF16, 1'b0, 64'h0, {48'h0, random_bf16(100, 55)});  // zero operand
    send_item(PREC_BF16, 1'b0, {48'h0, 1'b1, 8'd20, 7'h33}, {48'h0, 1'b0, 8'd30, 7'h11});
    send_item(PREC_BF16, 1'b0, {48'h0, 1'b0, 8'd63, 7'h00}, {48'h0, 1'b0, 8'd64, 7'h00});
    send_item(PREC_BF16, 1'b0, {48'h0, 1'b0, 8'd63, 7'h7f}, {48'h0, 1'b0, 8'd64, 7'h7f});
    send_item(PREC_BF16, 1'b0, {48'h0, 1'b1, 8'd250, 7'h40}, {48'h0, 1'b0, 8'd200, 7'h7f});
    send_item(PREC_BF16, 1'b0, {48'h0, 1'b0, 8'd190, 7'h00}, {48'h0, 1'b0, 8'd192, 7'h00});
    finish_test("bfloat16 products");

    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      p = prec_e'(r[1:0]);
      if (p == PREC_BF16) begin
        send_item(p, r[2], {random_word()} & ~64'hffff | 64'(random_bf16(1, 254)),
                  {random_word()} & ~64'hffff | 64'(random_bf16(1, 254)));
      end else begin
        send_item(p, r[2], random_word(), random_word());
      end
      if (r[5:3] == 3'd0) idle_cycles(1 + int'(r[7:6]));  // random gap
    end
    finish_test("mixed stream");

    // reset with two items in flight
    send_item(PREC_INT16, 1'b0, random_word(), random_word());
    send_item(PREC_INT16, 1'b1, random_word(), random_word());
    reset_i = 1'b1;
    u_smac_monitor.flush_expected();
    shadow_acc = '0;                                  // accumulator clears with reset
    idle_cycles(3);
    reset_i = 1'b0;
    send_item(PREC_INT16, 1'b1, random_word(), random_word());
    send_item(PREC_INT32, 1'b1, random_word(), random_word());
    finish_test("reset mid-stream");

    total_errors = error_count + u_smac_top.u_smac_chk.fail_count;  // compares and timing
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, total_errors);
    if (total_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: smac.f
verilog/smac_pkg.sv
verilog/smac_op_if.sv
verilog/smac_prod_if.sv
verilog/operand_stage.sv
verilog/precision_mul_stage.sv
verilog/accum_stage.sv
verilog/smac_top.sv
sim/smac_chk.sv
sim/smac_monitor.sv
sim/smac_tb.sv

// File: verilog/accum_stage.sv
`timescale 1ns/1ps

module accum_stage #(
  parameter int ACC_W = 64                            // accumulator width, 32..64
) (
  input  logic                        clk,
  input  logic                        reset_i,
  smac_prod_if.rcv                    prod_i,         // products from multiply stage
  output logic [smac_pkg::WORD_W-1:0] result_o,       // sum or bf16 product
  output logic                        valid_o         // one pulse per result
);
  import smac_pkg::*;

  logic                     is_int;                   // item goes through the accumulator
  logic signed [ACC_W-1:0]  acc_q;                    // running sum
  logic signed [ACC_W-1:0]  acc_base;                 // old sum or zero
  logic signed [ACC_W-1:0]  acc_next;                 // sum after this item
  logic signed [WORD_W-1:0] acc_ext;                  // sum sign extended to the word

  //////////////////////////////////////////////////////////////////////
  // accumulate
  //////////////////////////////////////////////////////////////////////

  assign is_int   = (prod_i.prec != PREC_BF16);
  assign acc_base = prod_i.accumulate ? acc_q : '0;   // flag low starts a new sum
  assign acc_next = acc_base + $signed(prod_i.product[ACC_W-1:0]);  // wraps mod 2**ACC_W
  assign acc_ext  = acc_next;

  // bf16 items leave the sum alone
  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc_q <= '0;
    end else if (prod_i.valid && is_int) begin
      acc_q <= acc_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= prod_i.valid;                        // third and last stage
    end
  end

  always_ff @(posedge clk) begin
    if (prod_i.valid) begin
      if (is_int) begin
        result_o <= acc_ext;
      end else begin
        result_o <= prod_i.product;                   // bf16 passes straight out
      end
    end
  end

endmodule

// File: verilog/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        ce_i,           // input strobe
  input  smac_pkg::prec_e             prec_i,         // precision of this word
  input  logic                        accumulate_i,   // add into running sum
  input  logic [smac_pkg::WORD_W-1:0] data_i,         // data word
  input  logic [smac_pkg::WORD_W-1:0] weight_i,       // weight word
  smac_op_if.drv                      op_o            // to multiply stage
);
  import smac_pkg::*;

  logic [WORD_W-1:0] a_ext;                           // data lane, extended to word
  logic [WORD_W-1:0] b_ext;                           // weight lane, extended to word

  //////////////////////////////////////////////////////////////////////
  // lane select
  //////////////////////////////////////////////////////////////////////

  // only the low lane is used, width follows the precision
  always_comb begin
    case (prec_i)
      PREC_INT8: begin
        a_ext = WORD_W'($signed(data_i[7:0]));        // sign extend 8 bit lane
        b_ext = WORD_W'($signed(weight_i[7:0]));
      end
      PREC_INT16: begin
        a_ext = WORD_W'($signed(data_i[15:0]));       // sign extend 16 bit lane
        b_ext = WORD_W'($signed(weight_i[15:0]));
      end
      PREC_INT32: begin
        a_ext = WORD_W'($signed(data_i[31:0]));       // sign extend 32 bit lane
        b_ext = WORD_W'($signed(weight_i[31:0]));
      end
      PREC_BF16: begin
        a_ext = WORD_W'(data_i[BF16_W-1:0]);          // raw bits, zero extended
        b_ext = WORD_W'(weight_i[BF16_W-1:0]);
      end
      default: begin
        a_ext = '0;
        b_ext = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // capture registers
  //////////////////////////////////////////////////////////////////////

  // strobe and control follow the inputs every edge
  always_ff @(posedge clk) begin
    if (reset_i) begin
      op_o.valid      <= 1'b0;                        // nothing in flight
      op_o.prec       <= PREC_INT8;
      op_o.accumulate <= 1'b0;
    end else begin
      op_o.valid      <= ce_i;
      op_o.prec       <= prec_i;
      op_o.accumulate <= accumulate_i;
    end
  end

  // operands held between strobes
  always_ff @(posedge clk) begin
    if (ce_i) begin
      op_o.a <= a_ext;
      op_o.b <= b_ext;
    end
  end

endmodule

// File: verilog/precision_mul_stage.sv
`timescale 1ns/1ps

module precision_mul_stage (
  input  logic     clk,
  input  logic     reset_i,
  smac_op_if.rcv   op_i,                              // captured operands
  smac_prod_if.drv prod_o                             // registered product
);
  import smac_pkg::*;

  localparam int SIG_W  = BF16_MAN_W + 1;             // significand with hidden one
  localparam int PROD_W = 2 * SIG_W;                  // significand product width
  localparam int ESUM_W = BF16_EXP_W + 2;             // exponent sum, carry and sign room

  //////////////////////////////////////////////////////////////////////
  // integer path
  //////////////////////////////////////////////////////////////////////

  logic signed [WORD_W-1:0] int_prod;                 // low word of signed product

  // operands already sign extended, int32 x int32 fits the word
  assign int_prod = $signed(op_i.a) * $signed(op_i.b);

  //////////////////////////////////////////////////////////////////////
  // bfloat16 path
  //////////////////////////////////////////////////////////////////////

  logic                     a_sign;
  logic                     b_sign;
  logic [BF16_EXP_W-1:0]    a_exp;                    // biased exponents
  logic [BF16_EXP_W-1:0]    b_exp;
  logic [SIG_W-1:0]         a_sig;                    // 1.mmmmmmm
  logic [SIG_W-1:0]         b_sig;
  logic [PROD_W-1:0]        sig_prod;                 // 01.x .. 11.x
  logic                     bf_sign;
  logic signed [ESUM_W-1:0] res_exp;                  // unbiased sum, may go negative
  logic [BF16_MAN_W-1:0]    res_man;                  // truncated mantissa
  logic [BF16_W-1:0]        bf_prod;                  // packed bf16 result

  // field split
  assign a_sign = op_i.a[BF16_W-1];
  assign b_sign = op_i.b[BF16_W-1];
  assign a_exp  = op_i.a[BF16_W-2 -: BF16_EXP_W];
  assign b_exp  = op_i.b[BF16_W-2 -: BF16_EXP_W];
  assign a_sig  = {1'b1, op_i.a[BF16_MAN_W-1:0]};     // hidden one restored
  assign b_sig  = {1'b1, op_i.b[BF16_MAN_W-1:0]};

  assign bf_sign  = a_sign ^ b_sign;                  // sign kept for zero and inf too
  assign sig_prod = a_sig * b_sig;                    // 8x8 unsigned

  always_comb begin
    // exponent sum with one bias removed
    res_exp = ESUM_W'(a_exp) + ESUM_W'(b_exp) - ESUM_W'(BF16_BIAS);

    if (sig_prod[PROD_W-1]) begin                     // product in [2,4)
      res_exp = res_exp + 1;                          // normalize one place
      res_man = sig_prod[PROD_W-2 -: BF16_MAN_W];
    end else begin                                    // product in [1,2)
      res_man = sig_prod[PROD_W-3 -: BF16_MAN_W];
    end

    if (a_exp == '0 || b_exp == '0 || res_exp <= 0) begin
      // zero input or underflow flushes to signed zero
      bf_prod = {bf_sign, {BF16_EXP_W{1'b0}}, {BF16_MAN_W{1'b0}}};
    end else if (res_exp >= BF16_EXP_MAX) begin
      // overflow saturates to infinity
      bf_prod = {bf_sign, BF16_EXP_W'(BF16_EXP_MAX), {BF16_MAN_W{1'b0}}};
    end else begin
      bf_prod = {bf_sign, res_exp[BF16_EXP_W-1:0], res_man};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // product select and register
  //////////////////////////////////////////////////////////////////////

  logic [WORD_W-1:0] prod_next;

  // bf16 result sits in the low 16 bits, upper bits zero
  assign prod_next = (op_i.prec == PREC_BF16) ? WORD_W'(bf_prod) : int_prod;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      prod_o.valid      <= 1'b0;
      prod_o.prec       <= PREC_INT8;
      prod_o.accumulate <= 1'b0;
    end else begin
      prod_o.valid      <= op_i.valid;                // one stage of latency
      prod_o.prec       <= op_i.prec;
      prod_o.accumulate <= op_i.accumulate;
    end
  end

  // payload loads only with a valid item
  always_ff @(posedge clk) begin
    if (op_i.valid) begin
      prod_o.product <= prod_next;
    end
  end

endmodule

// File: verilog/smac_op_if.sv
`timescale 1ns/1ps

// captured operands, operand stage to multiply stage
interface smac_op_if;
  import smac_pkg::*;

  logic              valid;                   // one cycle per item, no handshake
  prec_e             prec;                    // precision of this item
  logic              accumulate;              // add into running sum
  logic [WORD_W-1:0] a;                       // data lane, sign extended for int
  logic [WORD_W-1:0] b;                       // weight lane, sign extended for int

  // written by operand_stage
  modport drv (
    output valid, prec, accumulate, a, b
  );

  // read by precision_mul_stage
  modport rcv (
    input  valid, prec, accumulate, a, b
  );

endinterface

// File: verilog/smac_pkg.sv
package smac_pkg;

  //////////////////////////////////////////////////////////////////////
  // word widths
  //////////////////////////////////////////////////////////////////////

  localparam int WORD_W = 64;                 // data, weight and result word

  //////////////////////////////////////////////////////////////////////
  // run time precision
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,                        // signed, bits 7..0
    PREC_INT16 = 2'd1,                        // signed, bits 15..0
    PREC_INT32 = 2'd2,                        // signed, bits 31..0
    PREC_BF16  = 2'd3                         // bfloat16, bits 15..0, never accumulated
  } prec_e;

  //////////////////////////////////////////////////////////////////////
  // bfloat16 field layout
  //////////////////////////////////////////////////////////////////////

  localparam int BF16_EXP_W = 8;              // biased exponent bits
  localparam int BF16_MAN_W = 7;              // stored mantissa bits, hidden one not stored
  localparam int BF16_BIAS  = 127;            // exponent bias

  // sign + exponent + mantissa
  localparam int BF16_W = 1 + BF16_EXP_W + BF16_MAN_W;

  // all ones exponent marks infinity
  localparam int BF16_EXP_MAX = (1 << BF16_EXP_W) - 1;

endpackage

// File: verilog/smac_prod_if.sv
`timescale 1ns/1ps

// products, multiply stage to accumulate stage
interface smac_prod_if;
  import smac_pkg::*;

  logic              valid;                   // one cycle per item
  prec_e             prec;                    // carried along with the product
  logic              accumulate;              // carried along with the product
  logic [WORD_W-1:0] product;                 // int product, or bf16 in low 16 bits

  modport drv (
    output valid, prec, accumulate, product
  );

  modport rcv (
    input  valid, prec, accumulate, product
  );

endinterface

// File: verilog/smac_top.sv
`timescale 1ns/1ps

module smac_top #(
  parameter int ACC_W = 64                            // accumulator width, 32..64
) (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        ce_i,           // accept data and weight this cycle
  input  logic [1:0]                  prec_i,         // int8, int16, int32, bf16
  input  logic                        accumulate_i,   // add into the running sum
  input  logic [smac_pkg::WORD_W-1:0] data_i,
  input  logic [smac_pkg::WORD_W-1:0] weight_i,
  output logic [smac_pkg::WORD_W-1:0] result_o,       // three cycles after the strobe
  output logic                        valid_o
);

  //////////////////////////////////////////////////////////////////////
  // stage links
  //////////////////////////////////////////////////////////////////////

  smac_op_if   op_if ();                              // operand -> multiply
  smac_prod_if prod_if ();                            // multiply -> accumulate

  //////////////////////////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////////////////////////

  // operand capture stage
  operand_stage u_operand_stage (
    .clk          (clk),
    .reset_i      (reset_i),
    .ce_i         (ce_i),
    .prec_i       (smac_pkg::prec_e'(prec_i)),        // plain code to enum
    .accumulate_i (accumulate_i),
    .data_i       (data_i),
    .weight_i     (weight_i),
    .op_o         (op_if.drv)
  );

  // multiply stage
  precision_mul_stage u_precision_mul_stage (
    .clk     (clk),
    .reset_i (reset_i),
    .op_i    (op_if.rcv),
    .prod_o  (prod_if.drv)
  );

  // accumulate and output stage
  accum_stage #(
    .ACC_W (ACC_W)
  ) u_accum_stage (
    .clk      (clk),
    .reset_i  (reset_i),
    .prod_i   (prod_if.rcv),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

endmodule
